/* src/periph_macros.svh */
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// bus widths
`define PERIPH_ADDR_W 12
`define PERIPH_DATA_W 32
`define PERIPH_STRB_W 4

// pins on the gpio block
`define PERIPH_GPIO_W 8

// address region codes, addr[11:8]
`define PERIPH_REGION_GPIO 4'd0
`define PERIPH_REGION_INTC 4'd1

// register indexes, addr[7:2]
`define GPIO_REG_OUT 6'd0
`define GPIO_REG_OE 6'd1
`define GPIO_REG_IN 6'd2

`define INTC_REG_ENABLE 6'd0
`define INTC_REG_PENDING 6'd1

`endif

/* src/periph_pkg.sv */
`default_nettype none

`include "periph_macros.svh"

package periph_pkg;

  // only two regions are mapped, every other code is an error
  typedef enum logic [3:0] {
    REGION_GPIO = `PERIPH_REGION_GPIO,
    REGION_INTC = `PERIPH_REGION_INTC
  } region_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  typedef struct packed {
    region_e    region;
    logic [5:0] index;
    logic [1:0] lane;
  } addr_fields_t;

  // same 12 bits, flat or split into region / index / byte lane
  typedef union packed {
    logic [`PERIPH_ADDR_W-1:0] word;
    addr_fields_t              fields;
  } addr_u;

endpackage

`default_nettype wire

/* src/reg_bus_if.sv */
`default_nettype none
`timescale 1ns/1ps

`include "periph_macros.svh"

// single register access, answered in the same cycle
interface reg_bus_if;

  logic                      req;
  logic                      we;
  logic [5:0]                index;
  logic [`PERIPH_DATA_W-1:0] wdata;
  logic [`PERIPH_STRB_W-1:0] wstrb;
  logic [`PERIPH_DATA_W-1:0] rdata;
  logic                      err;

  modport front (
    output req, we, index, wdata, wstrb,
    input  rdata, err
  );

  modport target (
    input  req, we, index, wdata, wstrb,
    output rdata, err
  );

endinterface

`default_nettype wire

/* src/axil_front.sv */
`default_nettype none
`timescale 1ns/1ps

`include "periph_macros.svh"

module axil_front (
  input  wire                           dev_clk,
  input  wire                           rst_n,
  input  wire [`PERIPH_ADDR_W-1:0]      awaddr_i,
  input  wire                           awvalid_i,
  output logic                          awready_o,
  input  wire [`PERIPH_DATA_W-1:0]      wdata_i,
  input  wire [`PERIPH_STRB_W-1:0]      wstrb_i,
  input  wire                           wvalid_i,
  output logic                          wready_o,
  output periph_pkg::resp_e             bresp_o,
  output logic                          bvalid_o,
  input  wire                           bready_i,
  input  wire [`PERIPH_ADDR_W-1:0]      araddr_i,
  input  wire                           arvalid_i,
  output logic                          arready_o,
  output logic [`PERIPH_DATA_W-1:0]     rdata_o,
  output periph_pkg::resp_e             rresp_o,
  output logic                          rvalid_o,
  input  wire                           rready_i,
  reg_bus_if.front                      gpio_bus_o,
  reg_bus_if.front                      intc_bus_o
);

  periph_pkg::addr_u         acc_addr;
  logic                      busy;
  logic                      wr_acc;
  logic                      rd_acc;
  logic                      hit_gpio;
  logic                      hit_intc;
  logic                      sel_err;
  logic [`PERIPH_DATA_W-1:0] sel_rdata;
  logic                      bvalid_q;
  logic                      rvalid_q;
  periph_pkg::resp_e         bresp_q;
  periph_pkg::resp_e         rresp_q;
  logic [`PERIPH_DATA_W-1:0] rdata_q;

  // one transaction in flight, writes win a tie
  assign busy   = bvalid_q | rvalid_q;
  assign wr_acc = awvalid_i & wvalid_i & ~busy;
  assign rd_acc = arvalid_i & ~busy & ~wr_acc;

  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign arready_o = rd_acc;

  always_comb begin
    acc_addr.word = wr_acc ? awaddr_i : araddr_i;
  end

  // byte lane is ignored, accesses are word wide
  assign hit_gpio = (acc_addr.fields.region == periph_pkg::REGION_GPIO);
  assign hit_intc = (acc_addr.fields.region == periph_pkg::REGION_INTC);

  assign gpio_bus_o.req   = (wr_acc | rd_acc) & hit_gpio;
  assign gpio_bus_o.we    = wr_acc;
  assign gpio_bus_o.index = acc_addr.fields.index;
  assign gpio_bus_o.wdata = wdata_i;
  assign gpio_bus_o.wstrb = wstrb_i;

  assign intc_bus_o.req   = (wr_acc | rd_acc) & hit_intc;
  assign intc_bus_o.we    = wr_acc;
  assign intc_bus_o.index = acc_addr.fields.index;
  assign intc_bus_o.wdata = wdata_i;
  assign intc_bus_o.wstrb = wstrb_i;

  // unmapped regions answer slverr here, no target sees them
  always_comb begin
    if (hit_gpio) begin
      sel_err   = gpio_bus_o.err;
      sel_rdata = gpio_bus_o.rdata;
    end else if (hit_intc) begin
      sel_err   = intc_bus_o.err;
      sel_rdata = intc_bus_o.rdata;
    end else begin
      sel_err   = 1'b1;
      sel_rdata = '0;
    end
  end

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_acc) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_acc) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // held until the response handshake, nothing is accepted meanwhile
  always_ff @(posedge dev_clk) begin
    if (wr_acc) begin
      bresp_q <= sel_err ? periph_pkg::RESP_SLVERR : periph_pkg::RESP_OKAY;
    end
    if (rd_acc) begin
      rresp_q <= sel_err ? periph_pkg::RESP_SLVERR : periph_pkg::RESP_OKAY;
      rdata_q <= sel_err ? '0 : sel_rdata;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* src/gpio_regs.sv */
`default_nettype none
`timescale 1ns/1ps

`include "periph_macros.svh"

module gpio_regs (
  input  wire                        dev_clk,
  input  wire                        rst_n,
  reg_bus_if.target                  bus_i,
  input  wire [`PERIPH_GPIO_W-1:0]   gpio_i,
  output logic [`PERIPH_GPIO_W-1:0]  gpio_o,
  output logic [`PERIPH_GPIO_W-1:0]  gpio_oe,
  output logic [`PERIPH_GPIO_W-1:0]  pins_sync_o
);

  logic [`PERIPH_DATA_W-1:0] out_q;
  logic [`PERIPH_DATA_W-1:0] oe_q;
  logic [`PERIPH_GPIO_W-1:0] sync1_q;
  logic [`PERIPH_GPIO_W-1:0] sync2_q;
  logic                      wr_out;
  logic                      wr_oe;

  function automatic logic [`PERIPH_DATA_W-1:0] merge_bytes(
    input logic [`PERIPH_DATA_W-1:0] old_v,
    input logic [`PERIPH_DATA_W-1:0] new_v,
    input logic [`PERIPH_STRB_W-1:0] strb
  );
    logic [`PERIPH_DATA_W-1:0] res;
    res = old_v;
    for (int i = 0; i < `PERIPH_STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign wr_out = bus_i.req & bus_i.we & (bus_i.index == `GPIO_REG_OUT);
  assign wr_oe  = bus_i.req & bus_i.we & (bus_i.index == `GPIO_REG_OE);

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      out_q   <= '0;
      oe_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      if (wr_out) begin
        out_q <= merge_bytes(out_q, bus_i.wdata, bus_i.wstrb);
      end
      if (wr_oe) begin
        oe_q <= merge_bytes(oe_q, bus_i.wdata, bus_i.wstrb);
      end
      // two-flop synchronizer on the pads
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
    end
  end

  // input register is read-only
  always_comb begin
    bus_i.err   = 1'b0;
    bus_i.rdata = '0;
    case (bus_i.index)
      `GPIO_REG_OUT: bus_i.rdata = out_q;
      `GPIO_REG_OE:  bus_i.rdata = oe_q;
      `GPIO_REG_IN: begin
        bus_i.rdata = {{(`PERIPH_DATA_W-`PERIPH_GPIO_W){1'b0}}, sync2_q};
        bus_i.err   = bus_i.we;
      end
      default:       bus_i.err = 1'b1;
    endcase
  end

  // upper register bits have no pins but read back
  assign gpio_o      = out_q[`PERIPH_GPIO_W-1:0];
  assign gpio_oe     = oe_q[`PERIPH_GPIO_W-1:0];
  assign pins_sync_o = sync2_q;

endmodule

`default_nettype wire

/* src/irq_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "periph_macros.svh"

module irq_ctrl (
  input  wire                       dev_clk,
  input  wire                       rst_n,
  reg_bus_if.target                 bus_i,
  input  wire [`PERIPH_GPIO_W-1:0]  pins_sync_i,
  output logic                      irq_o
);

  logic [`PERIPH_GPIO_W-1:0] pins_prev_q;
  logic [`PERIPH_GPIO_W-1:0] enable_q;
  logic [`PERIPH_GPIO_W-1:0] pending_q;
  logic [`PERIPH_GPIO_W-1:0] rise;
  logic [`PERIPH_GPIO_W-1:0] clr;
  logic                      wr_en;
  logic                      wr_pend;

  // all registers live in byte lane 0
  assign wr_en   = bus_i.req & bus_i.we & bus_i.wstrb[0] &
                   (bus_i.index == `INTC_REG_ENABLE);
  assign wr_pend = bus_i.req & bus_i.we & bus_i.wstrb[0] &
                   (bus_i.index == `INTC_REG_PENDING);

  assign rise = pins_sync_i & ~pins_prev_q & enable_q;
  assign clr  = wr_pend ? bus_i.wdata[`PERIPH_GPIO_W-1:0] : '0;

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      pins_prev_q <= '0;
      enable_q    <= '0;
      pending_q   <= '0;
    end else begin
      pins_prev_q <= pins_sync_i;
      if (wr_en) begin
        enable_q <= bus_i.wdata[`PERIPH_GPIO_W-1:0];
      end
      // a fresh edge beats a clear in the same cycle
      pending_q <= (pending_q & ~clr) | rise;
    end
  end

  always_comb begin
    bus_i.err   = 1'b0;
    bus_i.rdata = '0;
    case (bus_i.index)
      `INTC_REG_ENABLE:  bus_i.rdata[`PERIPH_GPIO_W-1:0] = enable_q;
      `INTC_REG_PENDING: bus_i.rdata[`PERIPH_GPIO_W-1:0] = pending_q;
      default:           bus_i.err = 1'b1;
    endcase
  end

  assign irq_o = |pending_q;

endmodule

`default_nettype wire

/* src/periph_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "periph_macros.svh"

module periph_top (
  input  wire                        dev_clk,
  input  wire                        rst_n,
  input  wire [`PERIPH_ADDR_W-1:0]   awaddr_i,
  input  wire                        awvalid_i,
  output logic                       awready_o,
  input  wire [`PERIPH_DATA_W-1:0]   wdata_i,
  input  wire [`PERIPH_STRB_W-1:0]   wstrb_i,
  input  wire                        wvalid_i,
  output logic                       wready_o,
  output periph_pkg::resp_e          bresp_o,
  output logic                       bvalid_o,
  input  wire                        bready_i,
  input  wire [`PERIPH_ADDR_W-1:0]   araddr_i,
  input  wire                        arvalid_i,
  output logic                       arready_o,
  output logic [`PERIPH_DATA_W-1:0]  rdata_o,
  output periph_pkg::resp_e          rresp_o,
  output logic                       rvalid_o,
  input  wire                        rready_i,
  input  wire [`PERIPH_GPIO_W-1:0]   gpio_i,
  output logic [`PERIPH_GPIO_W-1:0]  gpio_o,
  output logic [`PERIPH_GPIO_W-1:0]  gpio_oe,
  output logic                       irq_o
);

  logic [`PERIPH_GPIO_W-1:0] pins_sync;

  reg_bus_if gpio_bus ();
  reg_bus_if intc_bus ();

  axil_front i_axil_front (
    .dev_clk    (dev_clk),
    .rst_n      (rst_n),
    .awaddr_i   (awaddr_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .bresp_o    (bresp_o),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .araddr_i   (araddr_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .gpio_bus_o (gpio_bus.front),
    .intc_bus_o (intc_bus.front)
  );

  gpio_regs i_gpio_regs (
    .dev_clk     (dev_clk),
    .rst_n       (rst_n),
    .bus_i       (gpio_bus.target),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe     (gpio_oe),
    .pins_sync_o (pins_sync)
  );

  // synchronized pins double as interrupt sources
  irq_ctrl i_irq_ctrl (
    .dev_clk     (dev_clk),
    .rst_n       (rst_n),
    .bus_i       (intc_bus.target),
    .pins_sync_i (pins_sync),
    .irq_o       (irq_o)
  );

endmodule

`default_nettype wire

/* dv/periph_props.sv */
`default_nettype none
`timescale 1ns/1ps

`include "periph_macros.svh"

module periph_props (
  input wire                             dev_clk,
  input wire                             rst_n,
  input wire                             awvalid_i,
  input wire                             awready_o,
  input wire                             wvalid_i,
  input wire                             wready_o,
  input wire periph_pkg::resp_e          bresp_o,
  input wire                             bvalid_o,
  input wire                             bready_i,
  input wire                             arready_o,
  input wire [`PERIPH_DATA_W-1:0]        rdata_o,
  input wire periph_pkg::resp_e          rresp_o,
  input wire                             rvalid_o,
  input wire                             rready_i
);

  int fail_cnt = 0;

  // responses stay put until the master takes them
  b_held: assert property (@(posedge dev_clk) disable iff (!rst_n)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else begin
      $error("write response dropped or changed before bready");
      fail_cnt++;
    end

  r_held: assert property (@(posedge dev_clk) disable iff (!rst_n)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rdata_o))
    else begin
      $error("read response dropped or changed before rready");
      fail_cnt++;
    end

  aw_w_ready: assert property (@(posedge dev_clk) disable iff (!rst_n)
    (awready_o || wready_o) |-> (awvalid_i && wvalid_i))
    else begin
      $error("awready or wready high without both valids");
      fail_cnt++;
    end

  // one transaction in flight
  no_ready_busy: assert property (@(posedge dev_clk) disable iff (!rst_n)
    (bvalid_o || rvalid_o) |-> !(awready_o || wready_o || arready_o))
    else begin
      $error("ready raised while a response is outstanding");
      fail_cnt++;
    end

endmodule

bind periph_top periph_props i_periph_props (.*);

`default_nettype wire

/* dv/periph_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "periph_macros.svh"

module periph_tb;

  localparam int SEED = 32'h75d3_49a6;

  logic                       dev_clk;
  logic                       rst_n;
  logic [`PERIPH_ADDR_W-1:0]  awaddr_i;
  logic                       awvalid_i;
  logic                       awready_o;
  logic [`PERIPH_DATA_W-1:0]  wdata_i;
  logic [`PERIPH_STRB_W-1:0]  wstrb_i;
  logic                       wvalid_i;
  logic                       wready_o;
  periph_pkg::resp_e          bresp_o;
  logic                       bvalid_o;
  logic                       bready_i;
  logic [`PERIPH_ADDR_W-1:0]  araddr_i;
  logic                       arvalid_i;
  logic                       arready_o;
  logic [`PERIPH_DATA_W-1:0]  rdata_o;
  periph_pkg::resp_e          rresp_o;
  logic                       rvalid_o;
  logic                       rready_i;
  logic [`PERIPH_GPIO_W-1:0]  gpio_i;
  logic [`PERIPH_GPIO_W-1:0]  gpio_o;
  logic [`PERIPH_GPIO_W-1:0]  gpio_oe;
  logic                       irq_o;

  // one entry per test line
  logic [7:0]                 op_q[$];
  logic [`PERIPH_ADDR_W-1:0]  addr_q[$];
  logic [`PERIPH_DATA_W-1:0]  data_q[$];
  logic [`PERIPH_STRB_W-1:0]  strb_q[$];
  periph_pkg::resp_e          resp_q[$];
  logic [`PERIPH_DATA_W-1:0]  exp_q[$];
  logic [8*24-1:0]            name_q[$];
  int                         cycles = 0;
  int                         limit = 0;

  periph_top i_periph_top (.*);

  initial begin
    dev_clk = 1'b0;
    forever #50 dev_clk = ~dev_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_resp(input logic [8*24-1:0] name, input periph_pkg::resp_e exp,
                            input periph_pkg::resp_e act);
    if (act !== exp) begin
      fail_run($sformatf("FAIL %0s expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_data(input logic [8*24-1:0] name, input logic [`PERIPH_DATA_W-1:0] exp,
                            input logic [`PERIPH_DATA_W-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("FAIL %0s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_pins(input logic [8*24-1:0] name, input logic [`PERIPH_GPIO_W-1:0] exp,
                            input logic [`PERIPH_GPIO_W-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("FAIL %0s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_irq(input logic [8*24-1:0] name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("FAIL %0s expected irq %b actual %b", name, exp, act));
    end
  endtask

  // back-pressure before each response
  task automatic wait_random_idle();
    int n;
    n = $urandom % 4;
    repeat (n) @(posedge dev_clk);
  endtask

  task automatic await_bresp(output periph_pkg::resp_e resp);
    wait_random_idle();
    bready_i <= 1'b1;
    do begin
      @(posedge dev_clk);
    end while (!bvalid_o);
    resp = bresp_o;
    bready_i <= 1'b0;
  endtask

  task automatic await_rresp(output periph_pkg::resp_e resp,
                             output logic [`PERIPH_DATA_W-1:0] data);
    wait_random_idle();
    rready_i <= 1'b1;
    do begin
      @(posedge dev_clk);
    end while (!rvalid_o);
    resp = rresp_o;
    data = rdata_o;
    rready_i <= 1'b0;
  endtask

  // address leads data by one cycle
  task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] addr,
                           input logic [`PERIPH_DATA_W-1:0] data,
                           input logic [`PERIPH_STRB_W-1:0] strb,
                           output periph_pkg::resp_e resp_a,
                           output periph_pkg::resp_e resp_b);
    @(posedge dev_clk);
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    @(posedge dev_clk);
    wdata_i   <= data;
    wstrb_i   <= strb;
    wvalid_i  <= 1'b1;
    do begin
      @(posedge dev_clk);
    end while (!(awready_o && wready_o));
    // valids stay up so a second identical write waits behind the response
    await_bresp(resp_a);
    do begin
      @(posedge dev_clk);
    end while (!(awready_o && wready_o));
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    await_bresp(resp_b);
  endtask

  task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] addr,
                          output periph_pkg::resp_e resp_a,
                          output logic [`PERIPH_DATA_W-1:0] data_a,
                          output periph_pkg::resp_e resp_b,
                          output logic [`PERIPH_DATA_W-1:0] data_b);
    @(posedge dev_clk);
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    do begin
      @(posedge dev_clk);
    end while (!arready_o);
    // second read of the same register queued behind the response
    await_rresp(resp_a, data_a);
    do begin
      @(posedge dev_clk);
    end while (!arready_o);
    arvalid_i <= 1'b0;
    await_rresp(resp_b, data_b);
  endtask

  always @(posedge dev_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      fail_run($sformatf("run timed out after %0d cycles", cycles));
    end else if (i_periph_top.i_periph_props.fail_cnt != 0) begin
      fail_run("a bus protocol assertion failed");
    end
  end

  initial begin
    int                        fd;
    int                        cnt;
    int                        resp_v;
    string                     line;
    logic [7:0]                op;
    logic [`PERIPH_ADDR_W-1:0] addr;
    logic [`PERIPH_DATA_W-1:0] data;
    logic [`PERIPH_STRB_W-1:0] strb;
    logic [`PERIPH_DATA_W-1:0] exp;
    logic [8*24-1:0]           name;
    periph_pkg::resp_e         resp;
    periph_pkg::resp_e         resp2;
    logic [`PERIPH_DATA_W-1:0] rdata;
    logic [`PERIPH_DATA_W-1:0] rdata2;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    gpio_i    = '0;
    fd = $fopen("dv/periph_tests.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open the test file dv/periph_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%s %h %h %h %d %h %s", op, addr, data, strb, resp_v, exp, name);
        if (cnt != 7) begin
          fail_run({"malformed line in the test file: ", line});
        end
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        strb_q.push_back(strb);
        resp_q.push_back(periph_pkg::resp_e'(resp_v[1:0]));
        exp_q.push_back(exp);
        name_q.push_back(name);
      end
    end
    $fclose(fd);
    limit = 40 * op_q.size() + 100;

    repeat (3) @(posedge dev_clk);
    rst_n <= 1'b1;

    foreach (op_q[i]) begin
      case (op_q[i])
        "W": begin
          bus_write(addr_q[i], data_q[i], strb_q[i], resp, resp2);
          check_resp(name_q[i], resp_q[i], resp);
          check_resp(name_q[i], resp_q[i], resp2);
        end
        "R": begin
          bus_read(addr_q[i], resp, rdata, resp2, rdata2);
          check_resp(name_q[i], resp_q[i], resp);
          check_data(name_q[i], exp_q[i], rdata);
          check_resp(name_q[i], resp_q[i], resp2);
          check_data(name_q[i], exp_q[i], rdata2);
        end
        "P": begin
          @(posedge dev_clk);
          gpio_i <= data_q[i][`PERIPH_GPIO_W-1:0];
          repeat (4) @(posedge dev_clk);
          @(negedge dev_clk);
          check_irq(name_q[i], exp_q[i][0], irq_o);
        end
        "O": begin
          @(negedge dev_clk);
          check_pins(name_q[i], data_q[i][`PERIPH_GPIO_W-1:0], gpio_o);
          check_pins(name_q[i], exp_q[i][`PERIPH_GPIO_W-1:0], gpio_oe);
        end
        default: fail_run("unknown operation in the test file");
      endcase
    end

    @(negedge dev_clk);
    if (i_periph_top.i_periph_props.fail_cnt != 0) begin
      fail_run("a bus protocol assertion failed");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/periph_tests.txt */
# op addr data strb resp expected name  (resp 0 okay, 2 slverr)
# W write, R read, P drive pins then 4 cycles and expect irq_o, O expect gpio_o=data gpio_oe=exp
W 000 000000a5 f 0 00000000 wr_out
W 004 0000003c f 0 00000000 wr_oe
O 000 000000a5 0 0 0000003c pins_out_oe
R 000 00000000 0 0 000000a5 rd_out
R 004 00000000 0 0 0000003c rd_oe
W 000 12345678 f 0 00000000 wr_out_full
W 000 aabbccdd 6 0 00000000 wr_out_partial
R 000 00000000 0 0 12bbcc78 rd_out_merged
O 000 00000078 0 0 0000003c pins_merged
P 000 0000005a 0 0 00000000 set_pins
R 008 00000000 0 0 0000005a rd_in
W 008 000000ff f 2 00000000 wr_in_readonly
R 008 00000000 0 0 0000005a rd_in_kept
W 100 00000001 1 0 00000000 wr_enable
P 000 0000005b 0 0 00000001 edge_enabled
R 104 00000000 0 0 00000001 rd_pending
W 104 00000001 1 0 00000000 clr_pending
P 000 0000005b 0 0 00000000 irq_cleared
R 104 00000000 0 0 00000000 rd_pending_clr
P 000 000000db 0 0 00000000 edge_disabled
R 104 00000000 0 0 00000000 rd_pending_disabled
W 200 ffffffff f 2 00000000 wr_unmapped
R 200 00000000 0 2 00000000 rd_unmapped
R 00c 00000000 0 2 00000000 rd_bad_gpio_index
W 10c 000000ff f 2 00000000 wr_bad_intc_index
R 000 00000000 0 0 12bbcc78 rd_out_unchanged
R 100 00000000 0 0 00000001 rd_enable_unchanged

/* all.f */
+incdir+src
src/periph_pkg.sv
src/reg_bus_if.sv
src/axil_front.sv
src/gpio_regs.sv
src/irq_ctrl.sv
src/periph_top.sv
dv/periph_props.sv
dv/periph_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= periph_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
